//--- source/eeprom_pkg.sv
package eeprom_pkg;

    // 2 Kbyte part, 11-bit byte address
    localparam int addr_width = 11;
    localparam int block_bits = 3;                        // sent in the control byte
    localparam int word_width = addr_width - block_bits;  // sent as the word address

    localparam logic [3:0] device_code = 4'b1010;

    // one SCL bit period is four quarters
    localparam int quarter_cycles = 1;

    // bus condition kinds, start and repeated start share one waveform
    localparam logic cond_start = 1'b0;
    localparam logic cond_stop  = 1'b1;

    typedef enum logic [3:0] {
        idle,
        start,
        send_ctrl_w,
        send_word,
        send_data,
        restart,
        send_ctrl_r,
        read_data,
        stop,
        done
    } ctrl_state_t;

    typedef enum logic {
        op_write,   // send byte, sample slave ack
        op_read     // receive byte, drive master ack from last
    } shift_op_t;

endpackage

//--- source/eeprom_arbiter.sv
`timescale 1ns/1ps
module eeprom_arbiter (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              req0,
    input  logic                              we0,
    input  logic [eeprom_pkg::addr_width-1:0] addr0,
    input  logic [7:0]                        wdata0,
    input  logic                              req1,
    input  logic                              we1,
    input  logic [eeprom_pkg::addr_width-1:0] addr1,
    input  logic [7:0]                        wdata1,
    input  logic                              txn_done,
    input  logic [7:0]                        txn_rdata,
    output logic                              ack0,
    output logic [7:0]                        rdata0,
    output logic                              ack1,
    output logic [7:0]                        rdata1,
    output logic                              start_txn,
    output logic                              txn_we,
    output logic [eeprom_pkg::addr_width-1:0] txn_addr,
    output logic [7:0]                        txn_wdata
);
    typedef enum logic [1:0] {
        arb_free,
        arb_busy,
        arb_release
    } arb_state_t;

    arb_state_t state;
    logic       last_served;  // port that finished most recently
    logic       sel;          // port that owns the bus
    logic       pick;

    // on a tie the port not served last wins
    assign pick = (req0 && req1) ? ~last_served : req1;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state       <= arb_free;
            last_served <= 1'b1;  // so port 0 takes the first tie
            sel         <= 1'b0;
            start_txn   <= 1'b0;
            ack0        <= 1'b0;
            ack1        <= 1'b0;
        end else begin
            start_txn <= 1'b0;
            case (state)
                arb_free: begin
                    if (req0 || req1) begin
                        sel       <= pick;
                        start_txn <= 1'b1;
                        state     <= arb_busy;
                    end
                end
                arb_busy: begin
                    if (txn_done) begin
                        ack0        <= ~sel;
                        ack1        <= sel;
                        last_served <= sel;
                        state       <= arb_release;
                    end
                end
                arb_release: begin
                    if (!(sel ? req1 : req0)) begin  // wait for the owner to let go
                        ack0  <= 1'b0;
                        ack1  <= 1'b0;
                        state <= arb_free;
                    end
                end
                default: state <= arb_free;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == arb_free && (req0 || req1)) begin
            txn_we    <= pick ? we1 : we0;
            txn_addr  <= pick ? addr1 : addr0;
            txn_wdata <= pick ? wdata1 : wdata0;
        end
        if (state == arb_busy && txn_done) begin
            if (sel)
                rdata1 <= txn_rdata;
            else
                rdata0 <= txn_rdata;
        end
    end

    a_one_ack: assert property (@(posedge CLK) disable iff (RESET) !(ack0 && ack1));
    // req as seen on the edge that raised ack
    a_ack0_req: assert property (@(posedge CLK) disable iff (RESET)
        $rose(ack0) |-> $past(req0));
    a_ack1_req: assert property (@(posedge CLK) disable iff (RESET)
        $rose(ack1) |-> $past(req1));

endmodule

//--- source/eeprom_rw_ctrl.sv
`timescale 1ns/1ps
module eeprom_rw_ctrl (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              start_txn,
    input  logic                              txn_we,
    input  logic [eeprom_pkg::addr_width-1:0] txn_addr,
    input  logic [7:0]                        txn_wdata,
    input  logic                              shift_done,
    input  logic [7:0]                        shift_rx_byte,
    input  logic                              slave_ack,
    output logic                              txn_done,
    output logic [7:0]                        txn_rdata,
    output logic                              shift_go,
    output eeprom_pkg::shift_op_t             shift_op,
    output logic [7:0]                        shift_byte,
    output logic                              last,
    output logic                              cond_go,
    output logic                              cond_kind
);
    import eeprom_pkg::*;

    ctrl_state_t           state;
    ctrl_state_t           next_state;
    logic                  launch;   // first cycle of a new bus phase
    logic                  in_cond;
    logic [block_bits-1:0] blk;

    // high address bits ride in the control byte
    assign blk = txn_addr[addr_width-1 -: block_bits];

    assign in_cond  = (state == start) || (state == restart) || (state == stop);
    assign cond_go  = launch && in_cond;
    assign shift_go = launch && !in_cond;
    assign txn_done = (state == done);

    always_comb begin
        case (state)
            start:       next_state = send_ctrl_w;
            send_ctrl_w: next_state = send_word;
            send_word:   next_state = txn_we ? send_data : restart;
            restart:     next_state = send_ctrl_r;
            send_ctrl_r: next_state = read_data;
            send_data:   next_state = stop;
            read_data:   next_state = stop;
            stop:        next_state = done;
            default:     next_state = idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= idle;
            launch <= 1'b0;
        end else begin
            launch <= 1'b0;
            case (state)
                idle: begin
                    if (start_txn) begin
                        state  <= start;
                        launch <= 1'b1;
                    end
                end
                done: state <= idle;  // txn_done for one cycle
                default: begin
                    if (shift_done) begin
                        state  <= next_state;
                        launch <= (next_state != done);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == read_data && shift_done)
            txn_rdata <= shift_rx_byte;
    end

    // what the shifter is asked to do in each state
    always_comb begin
        shift_op   = op_write;
        shift_byte = 8'h00;
        last       = 1'b0;
        cond_kind  = cond_start;
        case (state)
            send_ctrl_w: shift_byte = {device_code, blk, 1'b0};
            send_word:   shift_byte = txn_addr[word_width-1:0];
            send_data:   shift_byte = txn_wdata;
            send_ctrl_r: shift_byte = {device_code, blk, 1'b1};
            read_data: begin
                shift_op = op_read;
                last     = 1'b1;  // single byte, answer with nack
            end
            stop:        cond_kind = cond_stop;
            default: ;
        endcase
    end

    // the EEPROM must acknowledge every byte we send it
    a_slave_ack: assert property (@(posedge CLK) disable iff (RESET)
        shift_done && !in_cond && shift_op == op_write |-> slave_ack)
        else $error("no acknowledge from EEPROM in state %s", state.name());

    a_start_idle: assert property (@(posedge CLK) disable iff (RESET)
        start_txn |-> state == idle);

endmodule

//--- source/i2c_byte_shifter.sv
`timescale 1ns/1ps
module i2c_byte_shifter (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  shift_go,
    input  eeprom_pkg::shift_op_t shift_op,
    input  logic [7:0]            shift_byte,
    input  logic                  last,
    input  logic                  cond_go,
    input  logic                  cond_kind,
    input  logic                  sda_in,
    output logic                  shift_done,
    output logic [7:0]            shift_rx_byte,
    output logic                  slave_ack,
    output logic                  scl,
    output logic                  sda_drive_low
);
    import eeprom_pkg::*;

    logic       busy;
    logic       is_cond;
    logic       kind_q;
    shift_op_t  op_q;
    logic       last_q;
    logic [7:0] tx_q;
    logic [7:0] rx_q;
    logic [1:0] phase;     // quarter of the bit period
    logic [3:0] bit_cnt;   // 8 is the ack bit
    logic [7:0] qdiv;
    logic       tick;
    logic       bit_out;   // 1 releases sda

    assign tick = (qdiv == 8'(quarter_cycles - 1));
    assign shift_rx_byte = rx_q;

    always_comb begin
        if (bit_cnt == 4'd8)
            bit_out = (op_q == op_write) ? 1'b1 : last_q;  // nack on the last read byte
        else
            bit_out = (op_q == op_write) ? tx_q[7] : 1'b1;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy          <= 1'b0;
            is_cond       <= 1'b0;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
            qdiv          <= 8'd0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            shift_done    <= 1'b0;
            slave_ack     <= 1'b0;
        end else begin
            shift_done <= 1'b0;
            if (!busy) begin
                phase   <= 2'd0;
                bit_cnt <= 4'd0;
                qdiv    <= 8'd0;
                if (shift_go || cond_go) begin
                    busy    <= 1'b1;
                    is_cond <= cond_go;
                end
            end else if (!tick) begin
                qdiv <= qdiv + 8'd1;
            end else begin
                qdiv  <= 8'd0;
                phase <= phase + 2'd1;
                if (is_cond) begin
                    // sda moves with scl high only here
                    case (phase)
                        2'd0: begin
                            if (kind_q == cond_stop) begin
                                scl           <= 1'b0;
                                sda_drive_low <= 1'b1;
                            end else begin
                                sda_drive_low <= 1'b0;
                            end
                        end
                        2'd1: scl <= 1'b1;
                        2'd2: sda_drive_low <= (kind_q != cond_stop);
                        default: begin
                            if (kind_q != cond_stop)
                                scl <= 1'b0;  // stop leaves the bus idle
                            busy       <= 1'b0;
                            shift_done <= 1'b1;
                        end
                    endcase
                end else begin
                    case (phase)
                        2'd0: begin
                            scl           <= 1'b0;
                            sda_drive_low <= ~bit_out;
                        end
                        2'd1: scl <= 1'b1;
                        2'd2: begin
                            if (bit_cnt == 4'd8 && op_q == op_write)
                                slave_ack <= ~sda_in;
                        end
                        default: begin
                            scl     <= 1'b0;
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'd8) begin
                                busy       <= 1'b0;
                                shift_done <= 1'b1;
                            end
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!busy && (shift_go || cond_go)) begin
            op_q   <= shift_op;
            last_q <= last;
            kind_q <= cond_kind;
            tx_q   <= shift_byte;
        end else if (busy && tick && !is_cond) begin
            if (phase == 2'd2 && bit_cnt != 4'd8 && op_q == op_read)
                rx_q <= {rx_q[6:0], sda_in};  // msb first
            if (phase == 2'd3)
                tx_q <= {tx_q[6:0], 1'b0};
        end
    end

    a_one_go: assert property (@(posedge CLK) disable iff (RESET) !(shift_go && cond_go));

endmodule

//--- source/eeprom_subsys_top.sv
`timescale 1ns/1ps
module eeprom_subsys_top (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              req0,
    input  logic                              we0,
    input  logic [eeprom_pkg::addr_width-1:0] addr0,
    input  logic [7:0]                        wdata0,
    input  logic                              req1,
    input  logic                              we1,
    input  logic [eeprom_pkg::addr_width-1:0] addr1,
    input  logic [7:0]                        wdata1,
    output logic                              ack0,
    output logic [7:0]                        rdata0,
    output logic                              ack1,
    output logic [7:0]                        rdata1,
    output logic                              scl,
    inout  wire                               sda
);
    import eeprom_pkg::*;

    logic                  start_txn;
    logic                  txn_we;
    logic [addr_width-1:0] txn_addr;
    logic [7:0]            txn_wdata;
    logic                  txn_done;
    logic [7:0]            txn_rdata;
    logic                  shift_go;
    shift_op_t             shift_op;
    logic [7:0]            shift_byte;
    logic                  last;
    logic                  cond_go;
    logic                  cond_kind;
    logic                  shift_done;
    logic [7:0]            shift_rx_byte;
    logic                  slave_ack;
    logic                  sda_drive_low;
    logic                  sda_in;

    eeprom_arbiter eeprom_arbiter_i (
        .CLK(CLK), .RESET(RESET),
        .req0(req0), .we0(we0), .addr0(addr0), .wdata0(wdata0),
        .req1(req1), .we1(we1), .addr1(addr1), .wdata1(wdata1),
        .txn_done(txn_done), .txn_rdata(txn_rdata),
        .ack0(ack0), .rdata0(rdata0), .ack1(ack1), .rdata1(rdata1),
        .start_txn(start_txn), .txn_we(txn_we), .txn_addr(txn_addr), .txn_wdata(txn_wdata)
    );

    eeprom_rw_ctrl eeprom_rw_ctrl_i (
        .CLK(CLK), .RESET(RESET),
        .start_txn(start_txn), .txn_we(txn_we), .txn_addr(txn_addr), .txn_wdata(txn_wdata),
        .shift_done(shift_done), .shift_rx_byte(shift_rx_byte), .slave_ack(slave_ack),
        .txn_done(txn_done), .txn_rdata(txn_rdata),
        .shift_go(shift_go), .shift_op(shift_op), .shift_byte(shift_byte), .last(last),
        .cond_go(cond_go), .cond_kind(cond_kind)
    );

    i2c_byte_shifter i2c_byte_shifter_i (
        .CLK(CLK), .RESET(RESET),
        .shift_go(shift_go), .shift_op(shift_op), .shift_byte(shift_byte), .last(last),
        .cond_go(cond_go), .cond_kind(cond_kind), .sda_in(sda_in),
        .shift_done(shift_done), .shift_rx_byte(shift_rx_byte), .slave_ack(slave_ack),
        .scl(scl), .sda_drive_low(sda_drive_low)
    );

    // open drain, pull-up sits outside
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

//--- bench/eeprom_model.sv
`timescale 1ns/1ps
module eeprom_model (
    input logic scl,
    inout wire  sda
);
    import eeprom_pkg::*;

    logic [7:0]            mem [0:(1 << addr_width) - 1];
    logic [7:0]            rx;
    logic [7:0]            tx;
    logic [addr_width-1:0] ptr;
    logic [block_bits-1:0] blk;
    logic                  active = 1'b0;
    logic                  reading = 1'b0;
    logic                  sda_low = 1'b0;
    int                    bit_n = 0;
    int                    byte_n = 0;

    assign sda = sda_low ? 1'b0 : 1'bz;

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active  = 1'b1;
            reading = 1'b0;
            bit_n   = -1;  // scl still falls once after start
            byte_n  = 0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1)
            active = 1'b0;  // stop
    end

    always @(posedge scl) begin
        if (active && bit_n >= 0 && bit_n < 8)
            rx = {rx[6:0], sda};
    end

    always @(negedge scl) begin
        if (active) begin
            if (bit_n == 7 && reading) begin
                bit_n   = 8;
                sda_low = 1'b0;   // master answers this one
                reading = 1'b0;   // single byte only
            end else if (bit_n == 7) begin
                bit_n = 8;
                take_byte();
            end else if (bit_n == 8) begin
                bit_n   = 0;
                sda_low = reading && !tx[7];
            end else begin
                bit_n   = bit_n + 1;
                sda_low = reading && !tx[7 - bit_n];
            end
        end
    end

    task automatic take_byte();
        if (byte_n == 0 && rx[7:4] != device_code) begin
            active  = 1'b0;  // not for us
            sda_low = 1'b0;
        end else begin
            if (byte_n == 0) begin
                blk = rx[3:1];
                if (rx[0]) begin
                    reading = 1'b1;
                    tx      = mem[{blk, ptr[word_width-1:0]}];
                end
            end else if (byte_n == 1) begin
                ptr = {blk, rx};
            end else begin
                mem[ptr] = rx;  // write cycle finishes at once
            end
            byte_n  = byte_n + 1;
            sda_low = 1'b1;
        end
    endtask

endmodule

//--- bench/tb_eeprom_subsys.sv
`timescale 1ns/1ps
module tb_eeprom_subsys;
    import eeprom_pkg::*;

    localparam int n_txn = 41;        // transactions issued by all tests
    localparam int txn_cycles = 200;  // a read runs about 175 cycles

    logic                       CLK = 1'b0;
    logic                       RESET;
    logic [1:0]                 req;
    logic [1:0]                 we;
    logic [1:0][addr_width-1:0] addr;
    logic [1:0][7:0]            wdata;
    wire  [1:0]                 ack;
    wire  [1:0][7:0]            rdata;
    wire                        scl;
    wire                        sda;

    logic [7:0]            sb [0:(1 << addr_width) - 1];
    logic [addr_width-1:0] written[$];
    logic [31:0]           rng = 32'd71770;
    logic                  order_armed = 1'b0;
    int                    first_port = 0;
    int                    errors = 0;
    int                    err_mark = 0;
    int                    tests_ok = 0;
    int                    tests_bad = 0;

    always #4 CLK = ~CLK;

    pullup (sda);

    eeprom_subsys_top eeprom_subsys_top_i (
        .CLK(CLK), .RESET(RESET),
        .req0(req[0]), .we0(we[0]), .addr0(addr[0]), .wdata0(wdata[0]),
        .req1(req[1]), .we1(we[1]), .addr1(addr[1]), .wdata1(wdata[1]),
        .ack0(ack[0]), .rdata0(rdata[0]), .ack1(ack[1]), .rdata1(rdata[1]),
        .scl(scl), .sda(sda)
    );

    eeprom_model eeprom_model_i (.scl(scl), .sda(sda));

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function void log_failure(input string msg);
        errors++;
        $display("FAILED %0t: %s", $time, msg);
    endfunction

    a_reset_idle: assert property (@(posedge CLK) $fell(RESET) |-> ack == 2'b00 && scl && sda)
        else log_failure("ack set or bus not released after reset");
    a_idle_bus: assert property (@(posedge CLK) disable iff (RESET) req == 2'b00 |-> scl && sda)
        else log_failure("scl or sda low with no request pending");
    a_one_ack: assert property (@(posedge CLK) disable iff (RESET) !(&ack))
        else log_failure("ack0 and ack1 high together");
    a_tie_order: assert property (@(posedge CLK) disable iff (RESET)
        order_armed && |ack |-> ack[first_port])
        else log_failure($sformatf("tie not served on port %0d first", first_port));

    for (genvar p = 0; p < 2; p++) begin : g_port
        // req as seen on the edge that raised ack
        a_ack_req: assert property (@(posedge CLK) disable iff (RESET)
            $rose(ack[p]) |-> $past(req[p]))
            else log_failure($sformatf("ack%0d rose without req", p));
        a_ack_drop: assert property (@(posedge CLK) disable iff (RESET)
            $fell(req[p]) |-> ##[0:2] !ack[p])
            else log_failure($sformatf("ack%0d still high two cycles after req fell", p));
        a_rdata: assert property (@(posedge CLK) disable iff (RESET)
            $rose(ack[p]) && !we[p] |-> rdata[p] == sb[addr[p]])
            else log_failure($sformatf("port %0d read %h at %h, expected %h",
                                       p, rdata[p], addr[p], sb[addr[p]]));
    end

    // first ack of a tie disarms the order check
    always @(posedge CLK) begin
        if (|ack)
            order_armed <= 1'b0;
    end

    task automatic run_txn(input int p, input logic w, input logic [addr_width-1:0] a,
                           input logic [7:0] d);
        @(negedge CLK);
        we[p]    = w;
        addr[p]  = a;
        wdata[p] = d;
        req[p]   = 1'b1;
        while (!ack[p])
            @(negedge CLK);
        if (w) begin
            sb[a] = d;
            written.push_back(a);
        end
        req[p] = 1'b0;
        while (ack[p])
            @(negedge CLK);
    endtask

    task automatic run_pair(input int first, input logic w,
                            input logic [addr_width-1:0] a0, input logic [addr_width-1:0] a1,
                            input logic [7:0] d0, input logic [7:0] d1);
        first_port  = first;
        order_armed = 1'b1;
        fork
            run_txn(0, w, a0, d0);
            run_txn(1, w, a1, d1);
        join
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("%0t test %s: ok", $time, name);
        end else begin
            tests_bad++;
            $display("%0t test %s: %0d errors", $time, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        int p;
        logic [addr_width-1:0] a;
        req   = 2'b00;
        we    = 2'b00;
        addr  = '0;
        wdata = '0;
        RESET = 1'b1;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        repeat (4) @(negedge CLK);
        finish_test("idle after reset");

        run_txn(0, 1'b1, 11'h123, 8'h5a);
        run_txn(0, 1'b0, 11'h123, 8'h00);
        finish_test("write then read on port 0");

        run_txn(0, 1'b1, 11'h0a5, 8'h3c);
        run_txn(1, 1'b1, 11'h5a5, 8'hc3);  // same word, other block
        run_txn(0, 1'b0, 11'h5a5, 8'h00);
        run_txn(1, 1'b0, 11'h0a5, 8'h00);  // port 1 served last
        finish_test("block bits");

        run_pair(0, 1'b1, 11'h210, 11'h611, 8'h11, 8'h22);
        run_txn(0, 1'b0, 11'h210, 8'h00);  // port 0 now served last
        run_pair(1, 1'b0, 11'h210, 11'h611, 8'h00, 8'h00);
        finish_test("simultaneous requests");

        for (int i = 0; i < 30; i++) begin
            rng = xorshift(rng);
            p = rng[0];
            if (rng[1]) begin
                run_txn(p, 1'b1, rng[12:2], rng[20:13]);
            end else begin
                a = written[rng[31:16] % written.size()];
                run_txn(p, 1'b0, a, 8'h00);
            end
        end
        finish_test("random traffic");

        $display("tests ok %0d, tests with errors %0d, check errors %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog
    initial begin
        #(n_txn * txn_cycles * 8 + 2000);
        $display("run timed out waiting for ack at %0t", $time);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- filelist.f
source/eeprom_pkg.sv
source/eeprom_arbiter.sv
source/eeprom_rw_ctrl.sv
source/i2c_byte_shifter.sv
source/eeprom_subsys_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_subsys.sv
